//--- Makefile
# Verilator build and run of the rv_core testbench

SIM = obj_dir/Vrv_core_tb

$(SIM): rv_core.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module rv_core_tb -f rv_core.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- rv_core.f
+incdir+src
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_imm_gen.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_datapath.sv
src/rv_core.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv

//--- src/rv_alu.sv
// integer ALU of the core
// the ten RV32I operations, shifts take srcb[4:0]

module rv_alu (
	input  rv_pkg::word_t   srca,
	input  rv_pkg::word_t   srcb,
	input  rv_pkg::alu_op_t alu_op,
	output rv_pkg::word_t   result
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = srcb[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = srca + srcb;
			ALU_SUB:  result = srca - srcb;
			ALU_SLL:  result = srca << shamt;
			ALU_SLT:  result = ($signed(srca) < $signed(srcb)) ? word_t'(1) : '0;
			ALU_SLTU: result = (srca < srcb) ? word_t'(1) : '0; // unsigned compare
			ALU_XOR:  result = srca ^ srcb;
			ALU_SRL:  result = srca >> shamt; // zero fill
			ALU_SRA:  result = word_t'($signed(srca) >>> shamt); // sign fill
			ALU_OR:   result = srca | srcb;
			ALU_AND:  result = srca & srcb;
			default:  result = '0;
		endcase
	end

endmodule : rv_alu

//--- src/rv_cfg.svh
// sizing and reset values for the RV32I core
// included by the package and by any module that needs the raw numbers

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width in bits
`define RV_XLEN 32

// integer register count, x0 included
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// lane widths used by sub-word loads and stores
`define RV_BYTE_W 8
`define RV_HALF_W 16

`endif

//--- src/rv_core.sv
// top level of the single-cycle RV32I core
// instruction and data memories sit outside and answer combinationally

module rv_core (
	input  logic          clk,
	input  logic          reset,
	input  rv_pkg::word_t instr,
	input  rv_pkg::word_t dmem_rdata,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata,
	output logic          memwrite
);
	import rv_pkg::*;

	ctrl_t ctrl; // decoder to datapath

	rv_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	rv_datapath u_datapath (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.instr      (instr),
		.dmem_rdata (dmem_rdata),
		.pc         (pc),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata)
	);

	assign memwrite = ctrl.memwrite; // store strobe, one full word

endmodule : rv_core

//--- src/rv_datapath.sv
// datapath of the single-cycle core
// pc, register file, ALU, immediates, load/store alignment and branch compare

`include "rv_cfg.svh"

module rv_datapath (
	input  logic          clk,
	input  logic          reset,
	input  rv_pkg::ctrl_t ctrl,
	input  rv_pkg::word_t instr,
	input  rv_pkg::word_t dmem_rdata,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata
);
	import rv_pkg::*;

	reg_addr_t rs1, rs2, rd;
	word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t     rs1_data, rs2_data;
	word_t     srcb;
	word_t     alu_result;
	word_t     load_value;
	word_t     wb_data;
	word_t     pc_plus4;
	word_t     pc_next;
	logic      br_cond;
	logic      br_taken;

	rv_imm_gen u_imm_gen (
		.instr (instr),
		.rs1   (rs1),
		.rs2   (rs2),
		.rd    (rd),
		.imm_i (imm_i),
		.imm_s (imm_s),
		.imm_b (imm_b),
		.imm_u (imm_u),
		.imm_j (imm_j)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.we       (ctrl.regwrite),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.wd       (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	// stores use the s format, everything else the i format
	assign srcb = ctrl.alusrc ? (ctrl.memwrite ? imm_s : imm_i) : rs2_data;

	rv_alu u_alu (
		.srca   (rs1_data),
		.srcb   (srcb),
		.alu_op (ctrl.alu_op),
		.result (alu_result)
	);

	rv_lsu u_lsu (
		.funct3     (ctrl.funct3),
		.addr_lo    (alu_result[1:0]),
		.rdata      (dmem_rdata),
		.store_data (rs2_data),
		.load_value (load_value),
		.store_word (dmem_wdata) // read-modify-write word
	);

	assign dmem_addr = alu_result;
	assign pc_plus4  = pc + word_t'(4);

	// branch compare on raw register values
	always_comb begin
		case (ctrl.funct3)
			3'b000:  br_cond = (rs1_data == rs2_data); // beq
			3'b001:  br_cond = (rs1_data != rs2_data); // bne
			3'b100:  br_cond = ($signed(rs1_data) < $signed(rs2_data));
			3'b101:  br_cond = ($signed(rs1_data) >= $signed(rs2_data));
			3'b110:  br_cond = (rs1_data < rs2_data); // bltu
			3'b111:  br_cond = (rs1_data >= rs2_data); // bgeu
			default: br_cond = 1'b0;
		endcase
	end

	assign br_taken = ctrl.branch & br_cond;

	// next pc, taken branch first
	always_comb begin
		if (br_taken)
			pc_next = pc + imm_b;
		else if (ctrl.jump)
			pc_next = pc + imm_j;
		else if (ctrl.jalr)
			pc_next = (rs1_data + imm_i) & ~word_t'(1); // clear bit 0
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= `RV_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// write-back select
	always_comb begin
		if (ctrl.jump || ctrl.jalr)
			wb_data = pc_plus4; // link address
		else if (ctrl.auipc)
			wb_data = pc + imm_u;
		else if (ctrl.lui)
			wb_data = imm_u;
		else if (ctrl.memtoreg)
			wb_data = load_value;
		else
			wb_data = alu_result;
	end

endmodule : rv_datapath

//--- src/rv_decoder.sv
// instruction decoder of the single-cycle core
// turns opcode, funct3 and funct7 into the packed control bundle

module rv_decoder (
	input  rv_pkg::word_t instr,
	output rv_pkg::ctrl_t ctrl
);
	import rv_pkg::*;

	opcode_t opcode;
	logic    funct7_b5; // picks sub and sra
	alu_op_t arith_op;  // op for reg and imm arithmetic

	assign opcode    = instr[6:0];
	assign funct7_b5 = instr[30];

	// funct3 map shared by OP and OP-IMM
	always_comb begin
		case (instr[14:12])
			3'b000:  arith_op = (opcode == OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD; // no subi
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL; // srai shares bit 30
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		ctrl        = '0;             // unknown opcode ends up as nop
		ctrl.alu_op = ALU_ADD;        // address and default sum
		ctrl.funct3 = instr[14:12];   // always passed through
		case (opcode)
			OP_REG: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_op   = arith_op;
			end
			OP_IMM: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = arith_op;
			end
			OP_LOAD: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1; // base plus imm_i
				ctrl.memtoreg = 1'b1;
			end
			OP_STORE: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1; // base plus imm_s
			end
			OP_BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB; // compare itself lives in datapath
			end
			OP_JAL: begin
				ctrl.regwrite = 1'b1;
				ctrl.jump     = 1'b1;
			end
			OP_JALR: begin
				ctrl.regwrite = 1'b1;
				ctrl.jalr     = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			OP_LUI: begin
				ctrl.regwrite = 1'b1;
				ctrl.lui      = 1'b1;
			end
			OP_AUIPC: begin
				ctrl.regwrite = 1'b1;
				ctrl.auipc    = 1'b1;
			end
			default: begin
				ctrl.regwrite = 1'b0; // fence, system and junk do nothing
			end
		endcase
	end

endmodule : rv_decoder

//--- src/rv_imm_gen.sv
// field slicer of the core
// register indices and the five sign-extended immediate formats

module rv_imm_gen (
	input  rv_pkg::word_t     instr,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	output rv_pkg::reg_addr_t rd,
	output rv_pkg::word_t     imm_i,
	output rv_pkg::word_t     imm_s,
	output rv_pkg::word_t     imm_b,
	output rv_pkg::word_t     imm_u,
	output rv_pkg::word_t     imm_j
);
	import rv_pkg::*;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	// instr[31] is the sign bit in every format
	assign imm_i = {{20{instr[31]}}, instr[31:20]}; // loads, jalr, op-imm
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // stores
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0}; // lui, auipc
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule : rv_imm_gen

//--- src/rv_lsu.sv
// load/store alignment of the core
// extracts and extends loads, merges sub-word stores into the word read back

`include "rv_cfg.svh"

module rv_lsu (
	input  logic [2:0]    funct3,
	input  logic [1:0]    addr_lo,
	input  rv_pkg::word_t rdata,
	input  rv_pkg::word_t store_data,
	output rv_pkg::word_t load_value,
	output rv_pkg::word_t store_word
);
	import rv_pkg::*;

	logic [`RV_BYTE_W-1:0] byte_sel;
	logic [`RV_HALF_W-1:0] half_sel;

	// lane picked by the low address bits
	assign byte_sel = rdata[{addr_lo, 3'b000} +: `RV_BYTE_W];
	assign half_sel = rdata[{addr_lo[1], 4'b0000} +: `RV_HALF_W]; // bit 0 ignored

	// funct3[2] set means zero extend
	always_comb begin
		case (funct3)
			3'b000:  load_value = {{(`RV_XLEN-`RV_BYTE_W){byte_sel[`RV_BYTE_W-1]}}, byte_sel}; // lb
			3'b001:  load_value = {{(`RV_XLEN-`RV_HALF_W){half_sel[`RV_HALF_W-1]}}, half_sel}; // lh
			3'b100:  load_value = {{(`RV_XLEN-`RV_BYTE_W){1'b0}}, byte_sel}; // lbu
			3'b101:  load_value = {{(`RV_XLEN-`RV_HALF_W){1'b0}}, half_sel}; // lhu
			default: load_value = rdata; // lw
		endcase
	end

	// old word with the addressed lane replaced
	always_comb begin
		store_word = rdata;
		case (funct3[1:0])
			2'b00: begin
				store_word[{addr_lo, 3'b000} +: `RV_BYTE_W] = store_data[`RV_BYTE_W-1:0]; // sb
			end
			2'b01: begin
				store_word[{addr_lo[1], 4'b0000} +: `RV_HALF_W] = store_data[`RV_HALF_W-1:0];
			end
			default: begin
				store_word = store_data; // sw overwrites all
			end
		endcase
	end

endmodule : rv_lsu

//--- src/rv_pkg.sv
// shared types for the single-cycle RV32I core
// modules import it inside the body and use scoped names on their ports

`include "rv_cfg.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t; // data or address word
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t; // register index
	typedef logic [6:0] opcode_t; // major opcode, instr[6:0]

	// major opcodes of the base integer set
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_t;

	// decoder to datapath control bundle
	typedef struct packed {
		logic    regwrite; // write rd this cycle
		logic    memwrite; // store to data port
		logic    memtoreg; // rd gets load value
		logic    alusrc;   // alu operand b is an immediate
		logic    branch;   // conditional branch, compare done in datapath
		logic    jump;     // jal
		logic    jalr;
		logic    lui;
		logic    auipc;
		alu_op_t alu_op;
		logic [2:0] funct3; // width and compare select
	} ctrl_t;

endpackage : rv_pkg

//--- src/rv_regfile.sv
// integer register file, two combinational reads and one clocked write
// x0 always reads back as zero

`include "rv_cfg.svh"

module rv_regfile (
	input  logic              clk,
	input  logic              we,
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	input  rv_pkg::reg_addr_t rd,
	input  rv_pkg::word_t     wd,
	output rv_pkg::word_t     rs1_data,
	output rv_pkg::word_t     rs2_data
);
	import rv_pkg::*;

	word_t regs [`RV_NREGS]; // storage only, contents undefined until written

	// write lands on the edge, visible to reads next cycle
	always_ff @(posedge clk) begin
		if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	assign rs1_data = (rs1 != '0) ? regs[rs1] : '0;
	assign rs2_data = (rs2 != '0) ? regs[rs2] : '0;

endmodule : rv_regfile

//--- verif/rv_core_assert.sv
// concurrent checks on the rv_core ports, bound into every rv_core instance
// fail_count sums the failures of all properties

module rv_core_assert (
	input logic          clk,
	input logic          reset,
	input rv_pkg::word_t instr,
	input rv_pkg::word_t pc,
	input logic          memwrite
);
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	int unsigned align_fails = 0;
	int unsigned known_fails = 0;
	int unsigned step_fails  = 0;
	int unsigned fail_count;
	opcode_t     opcode;
	logic        redirect; // jal, jalr or branch may leave the +4 path

	assign opcode     = instr[6:0];
	assign redirect   = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH);
	assign fail_count = align_fails + known_fails + step_fails;

	pc_aligned: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00)
		else begin
			$error("pc not word aligned: %h", pc);
			align_fails++;
		end

	memwrite_known: assert property (@(posedge clk) disable iff (!reset) !$isunknown(memwrite))
		else begin
			$error("memwrite unknown after reset");
			known_fails++;
		end

	// previous edge out of reset with a straight-line opcode
	pc_step: assert property (@(posedge clk) disable iff (!reset)
		$past(reset) && !$past(redirect) |-> pc == $past(pc) + 32'd4)
		else begin
			$error("pc did not step by 4, now %h", pc);
			step_fails++;
		end

endmodule : rv_core_assert

bind rv_core rv_core_assert u_assert (
	.clk      (clk),
	.reset    (reset),
	.instr    (instr),
	.pc       (pc),
	.memwrite (memwrite)
);

//--- verif/rv_core_tb.sv
// testbench for the single-cycle RV32I core, plays both instruction and data memory
// a table of instruction, read data and expected port values is replayed one row per cycle

module rv_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	localparam word_t nop = 32'h0000_0013; // addi x0, x0, 0

	typedef struct packed {
		word_t instr;
		word_t rdata; // dmem_rdata answered for this row
		word_t pc;    // expected fetch address
		logic  we;    // store row, address and data compared too
		word_t addr;
		word_t wdata;
	} row_t;

	logic  clk;
	logic  reset;
	word_t instr;
	word_t dmem_rdata;
	word_t pc;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  memwrite;
	row_t  rows[$];
	int    timeout_ns;

	rv_core i_dut (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.dmem_rdata (dmem_rdata),
		.pc         (pc),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.memwrite   (memwrite)
	);

	// instruction encoders, fields cut from int arguments
	function automatic word_t r_type(input int f7, rs2, rs1, f3, rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
	endfunction
	function automatic word_t i_type(input int imm, rs1, f3, rd, input opcode_t op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction
	function automatic word_t s_type(input int imm, rs2, rs1, f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
	endfunction
	function automatic word_t b_type(input int off, rs1, rs2, f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
	endfunction
	function automatic word_t u_type(input int imm, rd, input opcode_t op);
		return {imm[19:0], rd[4:0], op};
	endfunction
	function automatic word_t j_type(input int off, rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
	endfunction

	task automatic append_row(input word_t ins, rdata, exp_pc, input logic we,
		input word_t addr, wdata);
		row_t r;
		r = '{instr: ins, rdata: rdata, pc: exp_pc, we: we, addr: addr, wdata: wdata};
		rows.push_back(r);
	endtask

	// instruction at pc, then sw rd to 0x100 so the result shows on dmem_wdata
	task automatic check_through_store(input word_t at, ins, input int rd,
		input word_t rdata, value);
		append_row(ins, rdata, at, 1'b0, '0, '0);
		append_row(s_type(256, rd, 0, 2), '0, at + 4, 1'b1, 32'h0000_0100, value);
	endtask

	task automatic compare_word(input string name, input word_t exp, got);
		if (got !== exp) begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
			$display(">>> FAIL");
			$fatal(1, "port value mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// first failure of a bound assertion ends the run
	initial begin
		wait (i_dut.u_assert.fail_count != 0);
		$display("a bound assertion on the core ports failed at t=%0t", $time);
		$display(">>> FAIL");
		$fatal(1, "assertion failure");
	end

	initial begin
		reset      = 1'b0;
		instr      = nop; // no store while reset is low
		dmem_rdata = '0;

		// reset and sequencing, x1 = 5, x4 = -7, x5 = 3
		check_through_store(0, i_type(5, 0, 0, 1, OP_IMM), 1, '0, 5);
		check_through_store(8, u_type(32'h12345, 2, OP_LUI), 2, '0, 32'h1234_5000);
		check_through_store(16, u_type(1, 3, OP_AUIPC), 3, '0, 32'h0000_1010); // 16 + 0x1000
		check_through_store(24, i_type(-7, 0, 0, 4, OP_IMM), 4, '0, 32'hFFFF_FFF9);
		check_through_store(32, i_type(99, 0, 0, 0, OP_IMM), 0, '0, 0); // x0 ignores write
		check_through_store(40, i_type(3, 0, 0, 5, OP_IMM), 5, '0, 3);
		// register ops into x6
		check_through_store(48, r_type(0, 4, 1, 0, 6), 6, '0, 32'hFFFF_FFFE);  // 5 + -7
		check_through_store(56, r_type(32, 4, 1, 0, 6), 6, '0, 32'h0000_000C); // 5 - -7
		check_through_store(64, r_type(0, 5, 4, 1, 6), 6, '0, 32'hFFFF_FFC8);  // sll
		check_through_store(72, r_type(0, 1, 4, 2, 6), 6, '0, 1);              // -7 < 5
		check_through_store(80, r_type(0, 1, 4, 3, 6), 6, '0, 0);              // sltu
		check_through_store(88, r_type(0, 4, 1, 4, 6), 6, '0, 32'hFFFF_FFFC);  // xor
		check_through_store(96, r_type(0, 5, 4, 5, 6), 6, '0, 32'h1FFF_FFFF);  // srl zero fill
		check_through_store(104, r_type(32, 5, 4, 5, 6), 6, '0, 32'hFFFF_FFFF); // sra
		check_through_store(112, r_type(0, 4, 1, 6, 6), 6, '0, 32'hFFFF_FFFD); // or
		check_through_store(120, r_type(0, 4, 1, 7, 6), 6, '0, 1);             // and
		check_through_store(128, r_type(0, 1, 1, 0, 0), 0, '0, 0);             // add into x0
		check_through_store(136, r_type(0, 4, 1, 3, 6), 6, '0, 1);             // 5 <u big
		check_through_store(144, r_type(0, 4, 1, 2, 6), 6, '0, 0);             // 5 < -7 no
		// loads from 0x200 plus offset into x6
		check_through_store(152, i_type(512, 0, 0, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'hFFFF_FFC5);
		check_through_store(160, i_type(513, 0, 0, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_0031);
		check_through_store(168, i_type(514, 0, 0, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'hFFFF_FF9A);
		check_through_store(176, i_type(515, 0, 0, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_007E);
		check_through_store(184, i_type(512, 0, 4, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_00C5);
		check_through_store(192, i_type(513, 0, 4, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_0031);
		check_through_store(200, i_type(514, 0, 4, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_009A);
		check_through_store(208, i_type(515, 0, 4, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_007E);
		check_through_store(216, i_type(512, 0, 1, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_31C5);
		check_through_store(224, i_type(514, 0, 1, 6, OP_LOAD), 6, 32'h8001_F00F, 32'hFFFF_8001);
		check_through_store(232, i_type(512, 0, 5, 6, OP_LOAD), 6, 32'h8001_F00F, 32'h0000_F00F);
		check_through_store(240, i_type(514, 0, 5, 6, OP_LOAD), 6, 32'h7E9A_31C5, 32'h0000_7E9A);
		check_through_store(248, i_type(512, 0, 2, 6, OP_LOAD), 6, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
		// stores of x7 = cafeb0a5 at base x8 = 0x400 over old word 11223344
		append_row(u_type(32'hCAFEB, 7, OP_LUI), '0, 256, 1'b0, '0, '0);
		check_through_store(260, i_type(165, 7, 0, 7, OP_IMM), 7, '0, 32'hCAFE_B0A5);
		append_row(i_type(1024, 0, 0, 8, OP_IMM), '0, 268, 1'b0, '0, '0);
		append_row(s_type(16, 7, 8, 0), 32'h1122_3344, 272, 1'b1, 32'h410, 32'h1122_33A5);
		append_row(s_type(17, 7, 8, 0), 32'h1122_3344, 276, 1'b1, 32'h411, 32'h1122_A544);
		append_row(s_type(18, 7, 8, 0), 32'h1122_3344, 280, 1'b1, 32'h412, 32'h11A5_3344);
		append_row(s_type(19, 7, 8, 0), 32'h1122_3344, 284, 1'b1, 32'h413, 32'hA522_3344);
		append_row(s_type(-4, 7, 8, 1), 32'h1122_3344, 288, 1'b1, 32'h3FC, 32'h1122_B0A5);
		append_row(s_type(18, 7, 8, 1), 32'h1122_3344, 292, 1'b1, 32'h412, 32'hB0A5_3344);
		append_row(s_type(-8, 7, 8, 2), 32'h1122_3344, 296, 1'b1, 32'h3F8, 32'hCAFE_B0A5);
		// branches on x1 = 5 and x4 = -7, each taken and not
		append_row(b_type(12, 1, 1, 0), '0, 300, 1'b0, '0, '0); // beq taken
		append_row(b_type(12, 1, 4, 0), '0, 312, 1'b0, '0, '0);
		append_row(b_type(8, 1, 4, 1), '0, 316, 1'b0, '0, '0);  // bne taken
		append_row(b_type(8, 1, 1, 1), '0, 324, 1'b0, '0, '0);
		append_row(b_type(16, 4, 1, 4), '0, 328, 1'b0, '0, '0); // blt taken
		append_row(b_type(16, 1, 4, 4), '0, 344, 1'b0, '0, '0);
		append_row(b_type(8, 1, 4, 5), '0, 348, 1'b0, '0, '0);  // bge taken
		append_row(b_type(8, 4, 1, 5), '0, 356, 1'b0, '0, '0);
		append_row(b_type(12, 1, 4, 6), '0, 360, 1'b0, '0, '0); // bltu taken
		append_row(b_type(12, 4, 1, 6), '0, 372, 1'b0, '0, '0);
		append_row(b_type(-72, 4, 1, 7), '0, 376, 1'b0, '0, '0); // bgeu taken, backward
		append_row(b_type(-72, 1, 4, 7), '0, 304, 1'b0, '0, '0);
		// jumps, link values stored to 0x100
		append_row(j_type(92, 9), '0, 308, 1'b0, '0, '0);
		append_row(s_type(256, 9, 0, 2), '0, 400, 1'b1, 32'h100, 312);
		append_row(i_type(33, 8, 0, 10, OP_JALR), '0, 404, 1'b0, '0, '0); // 0x421, bit 0 dropped
		append_row(s_type(256, 10, 0, 2), '0, 1056, 1'b1, 32'h100, 408);

		timeout_ns = (rows.size() + 3) * 4 + 100; // rows plus reset plus margin
		fork
			begin
				#(timeout_ns);
				$display("watchdog expired after %0d ns before all rows were applied", timeout_ns);
				$display(">>> FAIL");
				$fatal(1, "timeout");
			end
		join_none

		repeat (3) @(posedge clk); // reset low for 3 cycles
		foreach (rows[i]) begin
			@(negedge clk);
			reset      = 1'b1; // released with the first row
			instr      = rows[i].instr;
			dmem_rdata = rows[i].rdata;
			#1; // outputs settled, well before the rising edge
			compare_word("pc", rows[i].pc, pc);
			compare_word("memwrite", word_t'(rows[i].we), word_t'(memwrite));
			if (rows[i].we) begin
				compare_word("dmem_addr", rows[i].addr, dmem_addr);
				compare_word("dmem_wdata", rows[i].wdata, dmem_wdata);
			end
		end

		$display(">>> PASS");
		$finish;
	end

endmodule : rv_core_tb
